//--- common/cache_pkg.sv
package cache_pkg;

  localparam int NUM_WAYS  = 4;
  localparam int SET_BITS  = 5;   // 32 sets.
  localparam int WORD_BITS = 4;   // 16 words, 64-byte line.
  localparam int TAG_BITS  = 32 - SET_BITS - WORD_BITS - 2;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;
  typedef logic [1:0]  way_idx_t;

  // lookup view of a byte address.
  typedef struct packed {
    logic [TAG_BITS-1:0]  tag;
    logic [SET_BITS-1:0]  set;
    logic [WORD_BITS-1:0] word;
    logic [1:0]           offset;
  } addr_fields_t;

  // flat on the bus side, split for tag compare and line indexing.
  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t field;
  } cache_addr_u;

endpackage

//--- common/avalon_pkg.sv
package avalon_pkg;

  // one cache line per burst.
  localparam int BURST_LEN = 16;

  typedef logic [4:0]  burst_cnt_t;
  typedef logic [31:0] av_addr_t;   // byte address.

endpackage

//--- way/cache_way.sv
module cache_way #(
  parameter int SET_BITS = cache_pkg::SET_BITS
) (
  input  logic                            clk,
  input  logic                            rest,
  input  logic [SET_BITS-1:0]             lookup_set,
  input  logic [cache_pkg::WORD_BITS-1:0] lookup_word,
  input  logic [cache_pkg::TAG_BITS-1:0]  lookup_tag,
  input  logic                            cpu_we,
  input  cache_pkg::word_t                cpu_wdata,
  input  cache_pkg::be_t                  cpu_be,
  input  logic                            meta_we,
  input  logic                            meta_dirty,
  input  logic [SET_BITS-1:0]             line_set,
  input  logic [cache_pkg::WORD_BITS-1:0] line_word,
  input  logic                            line_we,
  input  cache_pkg::word_t                line_wdata,
  output logic                            hit,
  output logic                            valid,
  output logic                            dirty,
  output logic [cache_pkg::TAG_BITS-1:0]  tag,
  output cache_pkg::word_t                rdata,
  output cache_pkg::word_t                line_rdata
);
  import cache_pkg::*;

  localparam int NUM_SETS = 1 << SET_BITS;

  logic [NUM_SETS-1:0] valid_bits;
  logic [NUM_SETS-1:0] dirty_bits;
  logic [TAG_BITS-1:0] tag_mem [NUM_SETS];
  word_t               data_mem [NUM_SETS << WORD_BITS];

  assign valid      = valid_bits[lookup_set];
  assign dirty      = dirty_bits[lookup_set];
  assign tag        = tag_mem[lookup_set];
  assign hit        = valid && (tag == lookup_tag);
  assign rdata      = data_mem[{lookup_set, lookup_word}];
  assign line_rdata = data_mem[{line_set, line_word}];   // burst side port.

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (meta_we) begin
      valid_bits[lookup_set] <= 1'b1;
      dirty_bits[lookup_set] <= meta_dirty;
    end else if (cpu_we) begin
      dirty_bits[lookup_set] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (meta_we) begin
      tag_mem[lookup_set] <= lookup_tag;
    end
  end

  // refill takes whole words, cpu stores honour byte enables.
  always_ff @(posedge clk) begin
    if (line_we) begin
      data_mem[{line_set, line_word}] <= line_wdata;
    end else if (cpu_we) begin
      for (int b = 0; b < 4; b++) begin
        if (cpu_be[b]) begin
          data_mem[{lookup_set, lookup_word}][8*b +: 8] <= cpu_wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- bus/avalon_burst_master.sv
module avalon_burst_master #(
  parameter int NUM_WAYS = cache_pkg::NUM_WAYS
) (
  input  logic                            clk,
  input  logic                            rest,
  input  logic                            wb_start,
  input  logic                            fill_start,
  input  avalon_pkg::av_addr_t            line_base,
  input  cache_pkg::way_idx_t             victim_way,
  input  logic                            av_waitrequest,
  input  cache_pkg::word_t                av_readdata,
  input  logic                            av_readdatavalid,
  input  cache_pkg::word_t                way_line_rdata [NUM_WAYS],
  output logic                            burst_done,
  output logic [cache_pkg::WORD_BITS-1:0] line_word,
  output logic [NUM_WAYS-1:0]             line_we,
  output cache_pkg::word_t                line_wdata,
  output avalon_pkg::av_addr_t            av_address,
  output logic                            av_read,
  output logic                            av_write,
  output cache_pkg::word_t                av_writedata,
  output cache_pkg::be_t                  av_byteenable,
  output logic                            av_beginbursttransfer,
  output avalon_pkg::burst_cnt_t          av_burstcount
);
  import cache_pkg::*;
  import avalon_pkg::*;

  typedef enum logic [1:0] {
    bs_idle,
    bs_write,
    bs_rcmd,
    bs_rdata
  } bstate_t;

  bstate_t              state;
  logic [WORD_BITS-1:0] beat;
  logic                 last_beat;

  assign last_beat = (beat == WORD_BITS'(BURST_LEN - 1));

  // outputs follow state and beat only, so they hold under waitrequest.
  assign av_address            = line_base;
  assign av_write              = (state == bs_write);
  assign av_read               = (state == bs_rcmd);
  assign av_writedata          = way_line_rdata[victim_way];
  assign av_byteenable         = '1;
  assign av_burstcount         = burst_cnt_t'(BURST_LEN);
  assign av_beginbursttransfer = av_read || (av_write && beat == '0);

  assign line_word  = beat;
  assign line_wdata = av_readdata;

  always_comb begin
    line_we = '0;
    if (state == bs_rdata && av_readdatavalid) begin
      line_we[victim_way] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state      <= bs_idle;
      beat       <= '0;
      burst_done <= 1'b0;
    end else begin
      burst_done <= 1'b0;
      case (state)
        bs_idle: begin
          beat <= '0;
          if (wb_start) begin
            state <= bs_write;
          end else if (fill_start) begin
            state <= bs_rcmd;
          end
        end
        bs_write: begin
          if (!av_waitrequest) begin   // beat accepted.
            beat <= beat + 1'b1;
            if (last_beat) begin
              burst_done <= 1'b1;
              state      <= bs_idle;
            end
          end
        end
        bs_rcmd: begin
          if (!av_waitrequest) begin
            state <= bs_rdata;
          end
        end
        bs_rdata: begin
          if (av_readdatavalid) begin   // gaps between beats are allowed.
            beat <= beat + 1'b1;
            if (last_beat) begin
              burst_done <= 1'b1;
              state      <= bs_idle;
            end
          end
        end
        default: state <= bs_idle;
      endcase
    end
  end

endmodule

//--- ctrl/cache_ctrl.sv
module cache_ctrl #(
  parameter int NUM_WAYS = cache_pkg::NUM_WAYS,
  parameter int SET_BITS = cache_pkg::SET_BITS
) (
  input  logic                            clk,
  input  logic                            rest,
  input  logic                            req_valid,
  input  logic                            req_write,
  input  cache_pkg::word_t                req_addr,
  input  cache_pkg::word_t                req_wdata,
  input  cache_pkg::be_t                  req_be,
  output logic                            req_ready,
  output logic                            rsp_valid,
  output cache_pkg::word_t                rsp_rdata,
  input  logic [NUM_WAYS-1:0]             way_hit,
  input  logic [NUM_WAYS-1:0]             way_valid,
  input  logic [NUM_WAYS-1:0]             way_dirty,
  input  cache_pkg::word_t                way_rdata [NUM_WAYS],
  input  logic [cache_pkg::TAG_BITS-1:0]  way_tag [NUM_WAYS],
  input  logic                            burst_done,
  output logic [SET_BITS-1:0]             lookup_set,
  output logic [cache_pkg::WORD_BITS-1:0] lookup_word,
  output logic [cache_pkg::TAG_BITS-1:0]  lookup_tag,
  output logic [NUM_WAYS-1:0]             cpu_we,
  output cache_pkg::word_t                cpu_wdata,
  output cache_pkg::be_t                  cpu_be,
  output logic [NUM_WAYS-1:0]             meta_we,
  output logic                            meta_dirty,
  output logic                            wb_start,
  output logic                            fill_start,
  output avalon_pkg::av_addr_t            line_base,
  output cache_pkg::way_idx_t             victim_way,
  output logic [SET_BITS-1:0]             line_set
);
  import cache_pkg::*;

  localparam int NUM_SETS = 1 << SET_BITS;

  typedef enum logic [2:0] {
    st_boot,
    st_idle,
    st_lookup,
    st_wb,
    st_fill,
    st_meta
  } state_t;

  state_t      state;
  cache_addr_u addr_q;
  logic        write_q;
  word_t       wdata_q;
  be_t         be_q;
  way_idx_t    rr_cnt [NUM_SETS];   // per-set eviction pointer.
  logic        any_hit;
  logic        any_free;
  way_idx_t    hit_way;
  way_idx_t    free_way;
  way_idx_t    pick_way;
  cache_addr_u fill_addr;
  cache_addr_u wb_addr;

  assign req_ready   = (state == st_idle);
  assign lookup_set  = addr_q.field.set;
  assign lookup_word = addr_q.field.word;
  assign lookup_tag  = addr_q.field.tag;
  assign line_set    = addr_q.field.set;
  assign cpu_wdata   = wdata_q;
  assign cpu_be      = be_q;
  assign meta_dirty  = write_q;   // a write miss leaves the line dirty.
  assign any_hit     = |way_hit;

  // scan downward so the lowest way wins.
  always_comb begin
    hit_way  = '0;
    free_way = '0;
    any_free = 1'b0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_way = way_idx_t'(w);
      end
      if (!way_valid[w]) begin
        any_free = 1'b1;
        free_way = way_idx_t'(w);
      end
    end
    pick_way = any_free ? free_way : rr_cnt[addr_q.field.set];
  end

  // line bases for refill and for the victim's writeback.
  always_comb begin
    fill_addr              = addr_q;
    fill_addr.field.word   = '0;
    fill_addr.field.offset = '0;
    wb_addr                = fill_addr;
    wb_addr.field.tag      = way_tag[pick_way];
  end

  always_comb begin
    cpu_we  = '0;
    meta_we = '0;
    if (state == st_lookup && any_hit && write_q) begin
      cpu_we[hit_way] = 1'b1;
    end
    if (state == st_meta) begin
      meta_we[victim_way] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state      <= st_boot;
      rsp_valid  <= 1'b0;
      wb_start   <= 1'b0;
      fill_start <= 1'b0;
      for (int s = 0; s < NUM_SETS; s++) begin
        rr_cnt[s] <= '0;
      end
    end else begin
      rsp_valid  <= 1'b0;
      wb_start   <= 1'b0;
      fill_start <= 1'b0;
      case (state)
        st_boot: state <= st_idle;
        st_idle: begin
          if (req_valid) begin
            state <= st_lookup;
          end
        end
        st_lookup: begin
          if (any_hit) begin
            rsp_valid <= 1'b1;
            state     <= st_idle;
          end else begin
            if (!any_free) begin
              rr_cnt[addr_q.field.set] <= rr_cnt[addr_q.field.set] + 1'b1;
            end
            if (way_dirty[pick_way]) begin
              wb_start <= 1'b1;
              state    <= st_wb;
            end else begin
              fill_start <= 1'b1;
              state      <= st_fill;
            end
          end
        end
        st_wb: begin
          if (burst_done) begin
            fill_start <= 1'b1;
            state      <= st_fill;
          end
        end
        st_fill: begin
          if (burst_done) begin
            state <= st_meta;
          end
        end
        st_meta: state <= st_lookup;   // replay, now a hit.
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      addr_q.raw <= req_addr;
      write_q    <= req_write;
      wdata_q    <= req_wdata;
      be_q       <= req_be;
    end
    if (state == st_lookup) begin
      if (any_hit) begin
        rsp_rdata <= way_rdata[hit_way];
      end else begin
        victim_way <= pick_way;
        line_base  <= way_dirty[pick_way] ? wb_addr.raw : fill_addr.raw;
      end
    end
    if (state == st_wb && burst_done) begin
      line_base <= fill_addr.raw;   // switch to the requested line.
    end
  end

endmodule

//--- hw/cache_top.sv
module cache_top #(
  parameter int NUM_WAYS = cache_pkg::NUM_WAYS,
  parameter int SET_BITS = cache_pkg::SET_BITS
) (
  input  logic                   clk,
  input  logic                   rest,
  input  logic                   req_valid,
  input  logic                   req_write,
  input  cache_pkg::word_t       req_addr,
  input  cache_pkg::word_t       req_wdata,
  input  cache_pkg::be_t         req_be,
  output logic                   req_ready,
  output logic                   rsp_valid,
  output cache_pkg::word_t       rsp_rdata,
  output avalon_pkg::av_addr_t   av_address,
  output logic                   av_read,
  output logic                   av_write,
  output cache_pkg::word_t       av_writedata,
  output cache_pkg::be_t         av_byteenable,
  output logic                   av_beginbursttransfer,
  output avalon_pkg::burst_cnt_t av_burstcount,
  input  logic                   av_waitrequest,
  input  cache_pkg::word_t       av_readdata,
  input  logic                   av_readdatavalid
);
  import cache_pkg::*;
  import avalon_pkg::*;

  logic [SET_BITS-1:0]  lookup_set;
  logic [SET_BITS-1:0]  line_set;
  logic [WORD_BITS-1:0] lookup_word;
  logic [WORD_BITS-1:0] line_word;
  logic [TAG_BITS-1:0]  lookup_tag;
  logic [NUM_WAYS-1:0]  way_hit;
  logic [NUM_WAYS-1:0]  way_valid;
  logic [NUM_WAYS-1:0]  way_dirty;
  logic [NUM_WAYS-1:0]  cpu_we;
  logic [NUM_WAYS-1:0]  meta_we;
  logic [NUM_WAYS-1:0]  line_we;
  logic [TAG_BITS-1:0]  way_tag [NUM_WAYS];
  word_t                way_rdata [NUM_WAYS];
  word_t                way_line_rdata [NUM_WAYS];
  word_t                cpu_wdata;
  word_t                line_wdata;
  be_t                  cpu_be;
  logic                 meta_dirty;
  logic                 wb_start;
  logic                 fill_start;
  logic                 burst_done;
  av_addr_t             line_base;
  way_idx_t             victim_way;

  cache_ctrl #(
    .NUM_WAYS (NUM_WAYS),
    .SET_BITS (SET_BITS)
  ) u_ctrl (
    .clk         (clk),
    .rest        (rest),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_be      (req_be),
    .req_ready   (req_ready),
    .rsp_valid   (rsp_valid),
    .rsp_rdata   (rsp_rdata),
    .way_hit     (way_hit),
    .way_valid   (way_valid),
    .way_dirty   (way_dirty),
    .way_rdata   (way_rdata),
    .way_tag     (way_tag),
    .burst_done  (burst_done),
    .lookup_set  (lookup_set),
    .lookup_word (lookup_word),
    .lookup_tag  (lookup_tag),
    .cpu_we      (cpu_we),
    .cpu_wdata   (cpu_wdata),
    .cpu_be      (cpu_be),
    .meta_we     (meta_we),
    .meta_dirty  (meta_dirty),
    .wb_start    (wb_start),
    .fill_start  (fill_start),
    .line_base   (line_base),
    .victim_way  (victim_way),
    .line_set    (line_set)
  );

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    cache_way #(
      .SET_BITS (SET_BITS)
    ) u_way (
      .clk         (clk),
      .rest        (rest),
      .lookup_set  (lookup_set),
      .lookup_word (lookup_word),
      .lookup_tag  (lookup_tag),
      .cpu_we      (cpu_we[w]),
      .cpu_wdata   (cpu_wdata),
      .cpu_be      (cpu_be),
      .meta_we     (meta_we[w]),
      .meta_dirty  (meta_dirty),
      .line_set    (line_set),
      .line_word   (line_word),
      .line_we     (line_we[w]),
      .line_wdata  (line_wdata),
      .hit         (way_hit[w]),
      .valid       (way_valid[w]),
      .dirty       (way_dirty[w]),
      .tag         (way_tag[w]),
      .rdata       (way_rdata[w]),
      .line_rdata  (way_line_rdata[w])
    );
  end

  avalon_burst_master #(
    .NUM_WAYS (NUM_WAYS)
  ) u_burst (
    .clk                   (clk),
    .rest                  (rest),
    .wb_start              (wb_start),
    .fill_start            (fill_start),
    .line_base             (line_base),
    .victim_way            (victim_way),
    .av_waitrequest        (av_waitrequest),
    .av_readdata           (av_readdata),
    .av_readdatavalid      (av_readdatavalid),
    .way_line_rdata        (way_line_rdata),
    .burst_done            (burst_done),
    .line_word             (line_word),
    .line_we               (line_we),
    .line_wdata            (line_wdata),
    .av_address            (av_address),
    .av_read               (av_read),
    .av_write              (av_write),
    .av_writedata          (av_writedata),
    .av_byteenable         (av_byteenable),
    .av_beginbursttransfer (av_beginbursttransfer),
    .av_burstcount         (av_burstcount)
  );

endmodule

//--- common/mem_pattern.svh
// fill pattern of the external memory, a function of the byte address.
function automatic cache_pkg::word_t init_word(input cache_pkg::word_t addr);
  return (addr * 32'h9e37_79b1) ^ {addr[7:0], addr[31:8]} ^ 32'h5a5a_0f0f;
endfunction

//--- test/avalon_mem_model.sv
module avalon_mem_model #(
  parameter int MEM_WORDS = 16384
) (
  input  logic                   clk,
  input  logic                   rest,
  input  logic [31:0]            rnd,
  input  avalon_pkg::av_addr_t   av_address,
  input  logic                   av_read,
  input  logic                   av_write,
  input  cache_pkg::word_t       av_writedata,
  input  cache_pkg::be_t         av_byteenable,
  input  logic                   av_beginbursttransfer,
  input  avalon_pkg::burst_cnt_t av_burstcount,
  output logic                   av_waitrequest,
  output cache_pkg::word_t       av_readdata,
  output logic                   av_readdatavalid
);
  import cache_pkg::*;
  import avalon_pkg::*;
  `include "mem_pattern.svh"

  localparam int IDX_BITS = $clog2(MEM_WORDS);

  word_t               mem [MEM_WORDS];
  logic [IDX_BITS-1:0] fill_idx;
  logic [IDX_BITS-1:0] rd_idx;
  logic [IDX_BITS-1:0] wr_idx;   // beat pointer inside a write burst.
  int                  rd_left;
  logic [31:0]         r;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      fill_idx      = IDX_BITS'(i);
      mem[fill_idx] = init_word(word_t'(i) << 2);
    end
    av_waitrequest   = 1'b0;
    av_readdata      = '0;
    av_readdatavalid = 1'b0;
    rd_idx           = '0;
    wr_idx           = '0;
    rd_left          = 0;
    r                = '0;
    forever begin
      // transfers seen here complete at the coming rising edge.
      @(negedge clk);
      r = rnd;
      if (!rest) begin
        rd_left = 0;
      end else begin
        if (av_write && !av_waitrequest) begin
          if (av_beginbursttransfer) begin
            wr_idx = av_address[IDX_BITS+1:2];
          end
          for (int b = 0; b < 4; b++) begin
            if (av_byteenable[b]) begin
              mem[wr_idx][8*b +: 8] = av_writedata[8*b +: 8];
            end
          end
          wr_idx = wr_idx + 1'b1;
        end
        if (av_read && !av_waitrequest) begin
          rd_idx  = av_address[IDX_BITS+1:2];
          rd_left = int'(av_burstcount);
        end
      end
      @(posedge clk);
      #1;
      av_waitrequest   = rest && (r[31:30] == 2'b00);   // stall about one cycle in four.
      av_readdatavalid = 1'b0;
      if (rd_left > 0 && r[29:28] != 2'b00) begin
        av_readdata      = mem[rd_idx];
        av_readdatavalid = 1'b1;
        rd_idx           = rd_idx + 1'b1;
        rd_left          = rd_left - 1;
      end
    end
  end

endmodule

//--- test/cache_assertions.sv
module cache_assertions (
  input logic                   clk,
  input logic                   rest,
  input logic                   av_waitrequest,
  input logic                   av_read,
  input logic                   av_write,
  input avalon_pkg::av_addr_t   av_address,
  input cache_pkg::word_t       av_writedata,
  input logic                   av_beginbursttransfer,
  input avalon_pkg::burst_cnt_t av_burstcount
);

  int fail_count = 0;   // failed assertions so far.

  // a stalled command must not move.
  a_hold_under_wait: assert property (@(posedge clk) disable iff (!rest)
    (av_read || av_write) && av_waitrequest |=>
      $stable(av_read) && $stable(av_write) && $stable(av_address) &&
      $stable(av_writedata) && $stable(av_burstcount) && $stable(av_beginbursttransfer))
    else begin
      fail_count++;
      $error("bus command changed while waitrequest was high");
    end

  // first write beat of a burst carries the begin flag.
  a_write_begins: assert property (@(posedge clk) disable iff (!rest)
    $rose(av_write) |-> av_beginbursttransfer)
    else begin
      fail_count++;
      $error("write burst started without beginbursttransfer");
    end

  a_begin_once: assert property (@(posedge clk) disable iff (!rest)
    av_write && av_beginbursttransfer && !av_waitrequest |=> !av_beginbursttransfer)
    else begin
      fail_count++;
      $error("beginbursttransfer repeated after the first write beat");
    end

  // one read command per refill.
  a_single_read: assert property (@(posedge clk) disable iff (!rest)
    av_read && !av_waitrequest |=> !av_read)
    else begin
      fail_count++;
      $error("read command held after it was accepted");
    end

endmodule

//--- test/cache_tb.sv
module cache_tb;
  import cache_pkg::*;
  import avalon_pkg::*;
  `include "mem_pattern.svh"

  localparam logic [31:0] SEED     = 32'hb357;
  localparam int          RAND_OPS = 300;
  localparam int          NUM_OPS  = RAND_OPS + 20;
  localparam int          TIMEOUT  = (NUM_OPS + 10) * 200;
  localparam int          TAG_BASE = 8;   // random ops use tags 8..13.
  localparam int          NUM_TAGS = 6;
  localparam int          SET_BASE = 6;   // and sets 6, 7.

  logic       clk;
  logic       rest;
  logic       req_valid;
  logic       req_write;
  word_t      req_addr;
  word_t      req_wdata;
  be_t        req_be;
  logic       req_ready;
  logic       rsp_valid;
  word_t      rsp_rdata;
  av_addr_t   av_address;
  logic       av_read;
  logic       av_write;
  word_t      av_writedata;
  be_t        av_byteenable;
  logic       av_beginbursttransfer;
  burst_cnt_t av_burstcount;
  logic       av_waitrequest;
  word_t      av_readdata;
  logic       av_readdatavalid;
  logic [31:0] bus_rnd;
  logic [31:0] op_rnd;

  int       cycle        = 0;
  int       checks       = 0;
  int       errors       = 0;
  int       issued       = 0;
  int       answered     = 0;
  int       accept_cycle = 0;
  int       rsp_cycle    = 0;
  int       rd_cmds      = 0;
  int       wr_bursts    = 0;
  int       wr_beats     = 0;
  int       wb_beat      = 0;
  av_addr_t last_rd_addr = '0;
  av_addr_t last_wr_base = '0;
  word_t    log_addr [$];   // every accepted write, in order.
  word_t    log_data [$];
  be_t      log_be [$];
  word_t    exp_data [$];
  logic     exp_read [$];

  cache_top #(
    .NUM_WAYS (NUM_WAYS),
    .SET_BITS (SET_BITS)
  ) UUT (.*);

  avalon_mem_model u_mem (
    .clk                   (clk),
    .rest                  (rest),
    .rnd                   (bus_rnd),
    .av_address            (av_address),
    .av_read               (av_read),
    .av_write              (av_write),
    .av_writedata          (av_writedata),
    .av_byteenable         (av_byteenable),
    .av_beginbursttransfer (av_beginbursttransfer),
    .av_burstcount         (av_burstcount),
    .av_waitrequest        (av_waitrequest),
    .av_readdata           (av_readdata),
    .av_readdatavalid      (av_readdatavalid)
  );

  bind avalon_burst_master cache_assertions u_assert (
    .clk                   (clk),
    .rest                  (rest),
    .av_waitrequest        (av_waitrequest),
    .av_read               (av_read),
    .av_write              (av_write),
    .av_address            (av_address),
    .av_writedata          (av_writedata),
    .av_beginbursttransfer (av_beginbursttransfer),
    .av_burstcount         (av_burstcount)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t make_addr(input int tag_n, input int set_n, input int word_n);
    cache_addr_u a;
    a.raw        = '0;
    a.field.tag  = TAG_BITS'(tag_n);
    a.field.set  = SET_BITS'(set_n);
    a.field.word = WORD_BITS'(word_n);
    return a.raw;
  endfunction

  // initial word with every earlier write merged in under its byte enables.
  function automatic word_t expected_read(input word_t addr);
    word_t v;
    v = init_word({addr[31:2], 2'b00});
    foreach (log_addr[i]) begin
      if (log_addr[i][31:2] == addr[31:2]) begin
        for (int b = 0; b < 4; b++) begin
          if (log_be[i][b]) begin
            v[8*b +: 8] = log_data[i][8*b +: 8];
          end
        end
      end
    end
    return v;
  endfunction

  task automatic check_word(input word_t got, input word_t want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_count(input burst_cnt_t got, input burst_cnt_t want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic check_be(input be_t got, input be_t want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR at time %0t: %s", $time, what);
  endtask

  task automatic check_hit_latency(input string what);
    checks++;
    if (rsp_cycle - accept_cycle != 2) begin
      report_error($sformatf("%s answered %0d cycles after acceptance instead of 2",
                             what, rsp_cycle - accept_cycle));
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  // one request, held until taken, then wait for its response.
  task automatic issue_op(input logic wr, input word_t addr, input word_t data, input be_t be);
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = data;
    req_be    = be;
    do begin
      @(negedge clk);
    end while (!req_ready);
    accept_cycle = cycle;
    exp_read.push_back(!wr);
    exp_data.push_back(wr ? '0 : expected_read(addr));
    if (wr) begin
      log_addr.push_back(addr);
      log_data.push_back(data);
      log_be.push_back(be);
    end
    issued++;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    wait (answered >= issued);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    bus_rnd = SEED;
    forever begin
      @(posedge clk);
      #1;
      bus_rnd = lcg_next(bus_rnd);
    end
  end

  initial begin
    while (cycle < TIMEOUT) begin
      @(posedge clk);
      cycle++;
    end
    $display("timeout: no completion after %0d cycles", cycle);
    $display("Some tests failed");
    $finish;
  end

  // bus assertion failures count as errors too.
  initial begin : count_assert_fails
    int seen;
    seen = 0;
    forever begin
      @(negedge clk);
      if (UUT.u_burst.u_assert.fail_count != seen) begin
        errors = errors + UUT.u_burst.u_assert.fail_count - seen;
        seen   = UUT.u_burst.u_assert.fail_count;
      end
    end
  end

  // response compare.
  initial begin : compare_rsp
    logic  is_read;
    word_t want;
    forever begin
      @(negedge clk);
      if (rest && rsp_valid) begin
        if (exp_read.size() == 0) begin
          report_error("response came with no request outstanding");
        end else begin
          is_read = exp_read.pop_front();
          want    = exp_data.pop_front();
          if (is_read) begin
            check_word(rsp_rdata, want, "read data");
          end
        end
        rsp_cycle = cycle;
        answered++;
      end
    end
  end

  // bus monitor, writeback words checked against the golden memory.
  initial begin
    forever begin
      @(negedge clk);
      if (rest && av_read && !av_waitrequest) begin
        rd_cmds++;
        last_rd_addr = av_address;
        check_count(av_burstcount, burst_cnt_t'(BURST_LEN), "read burst count");
        if (!av_beginbursttransfer) begin
          report_error("read command without beginbursttransfer");
        end
      end
      if (rest && av_write && !av_waitrequest) begin
        if (av_beginbursttransfer) begin
          wb_beat      = 0;
          wr_bursts++;
          last_wr_base = av_address;
          check_count(av_burstcount, burst_cnt_t'(BURST_LEN), "write burst count");
        end
        check_be(av_byteenable, 4'hf, "writeback byte enables");
        check_word(av_writedata, expected_read(last_wr_base + word_t'(wb_beat * 4)),
                   "writeback data");
        wb_beat++;
        wr_beats++;
      end
    end
  end

  initial begin : main
    int    e0;
    int    rd0;
    int    wb0;
    int    beats0;
    int    tag_n;
    int    set_n;
    int    word_n;
    word_t a;
    word_t data;
    be_t   be;
    logic  wr;
    rest      = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_be    = '0;
    op_rnd    = SEED;
    repeat (10) @(posedge clk);
    #1;
    rest = 1'b1;

    e0  = errors;
    rd0 = rd_cmds;
    wb0 = wr_bursts;
    a   = make_addr(2, 1, 3);
    issue_op(1'b0, a, '0, '0);
    check_count(burst_cnt_t'(rd_cmds - rd0), 5'd1, "read bursts on cold miss");
    check_count(burst_cnt_t'(wr_bursts - wb0), 5'd0, "write bursts on cold miss");
    check_word(last_rd_addr, make_addr(2, 1, 0), "read burst base");
    end_test("1 cold read miss", e0);

    e0  = errors;
    rd0 = rd_cmds;
    issue_op(1'b0, a, '0, '0);
    check_hit_latency("repeated read");
    issue_op(1'b0, make_addr(2, 1, 12), '0, '0);
    check_hit_latency("read in same line");
    check_count(burst_cnt_t'(rd_cmds - rd0), 5'd0, "read bursts on hit");
    end_test("2 read hit", e0);

    e0 = errors;
    issue_op(1'b1, make_addr(2, 1, 5), 32'hdead_beef, 4'b0101);
    check_hit_latency("write hit");
    issue_op(1'b0, make_addr(2, 1, 5), '0, '0);
    end_test("3 partial write", e0);

    e0 = errors;
    issue_op(1'b1, make_addr(1, 3, 0), 32'h1111_2222, 4'hf);
    issue_op(1'b1, make_addr(1, 3, 7), 32'h3333_4444, 4'b1100);
    for (int t = 2; t <= 4; t++) begin
      issue_op(1'b1, make_addr(t, 3, 0), word_t'(t) * 32'h0101_0101, 4'hf);
    end
    wb0    = wr_bursts;
    beats0 = wr_beats;
    issue_op(1'b1, make_addr(5, 3, 2), 32'h5555_6666, 4'b0011);   // set full, way 0 goes.
    check_count(burst_cnt_t'(wr_bursts - wb0), 5'd1, "writeback bursts on eviction");
    check_count(burst_cnt_t'(wr_beats - beats0), 5'd16, "writeback beats on eviction");
    check_word(last_wr_base, make_addr(1, 3, 0), "writeback base");
    issue_op(1'b0, make_addr(1, 3, 7), '0, '0);
    issue_op(1'b0, make_addr(1, 3, 0), '0, '0);
    end_test("4 dirty eviction", e0);

    e0 = errors;
    for (int n = 0; n < RAND_OPS; n++) begin
      op_rnd = lcg_next(op_rnd);
      wr     = op_rnd[31];
      tag_n  = TAG_BASE + int'(op_rnd[30:28]) % NUM_TAGS;
      set_n  = SET_BASE + int'(op_rnd[27]);
      word_n = int'(op_rnd[26:23]);
      be     = op_rnd[22:19];
      op_rnd = lcg_next(op_rnd);
      data   = op_rnd;
      issue_op(wr, make_addr(tag_n, set_n, word_n), data, be);
    end
    end_test("5 random ops", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+common
common/cache_pkg.sv
common/avalon_pkg.sv
way/cache_way.sv
bus/avalon_burst_master.sv
ctrl/cache_ctrl.sv
hw/cache_top.sv
test/avalon_mem_model.sv
test/cache_assertions.sv
test/cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= cache_tb
FILELIST  ?= sources.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "^All tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
